// ==== all.f ====
logic/exu_pkg.sv
logic/exu_alu.sv
logic/exu_branch.sv
logic/lsu_ctrl_fsm.sv
logic/lsu_wait_timer.sv
logic/lsu_data_path.sv
logic/exu_top.sv
verification/axi_mem_model.sv
verification/exu_tb.sv

// ==== logic/exu_alu.sv ====
`default_nettype none

module exu_alu (
  input  wire [2:0]               i_func,
  input  wire                     i_alt,
  input  wire [exu_pkg::XLEN-1:0] i_src1,
  input  wire [exu_pkg::XLEN-1:0] i_src2,
  output logic [exu_pkg::XLEN-1:0] o_res,
  output logic                    o_eq,
  output logic                    o_lt,
  output logic                    o_ltu
);

  logic [exu_pkg::XLEN-1:0] b_op;
  logic [exu_pkg::XLEN-1:0] sum;
  logic [exu_pkg::SHAMT_W-1:0] shamt;

  // two's complement subtract through the same adder
  assign b_op = i_alt ? ~i_src2 : i_src2;
  assign sum = i_src1 + b_op + {{(exu_pkg::XLEN - 1){1'b0}}, i_alt};
  assign shamt = i_src2[exu_pkg::SHAMT_W-1:0];

  // compare flags, shared with the branch unit
  assign o_eq = (i_src1 == i_src2);
  assign o_lt = ($signed(i_src1) < $signed(i_src2));
  assign o_ltu = (i_src1 < i_src2);

  always_comb begin
    case (i_func)
      exu_pkg::F_ADD: begin
        o_res = sum;
      end
      exu_pkg::F_SLL: begin
        o_res = i_src1 << shamt;
      end
      exu_pkg::F_SLT: begin
        o_res = {{(exu_pkg::XLEN - 1){1'b0}}, o_lt};
      end
      exu_pkg::F_SLTU: begin
        o_res = {{(exu_pkg::XLEN - 1){1'b0}}, o_ltu};
      end
      exu_pkg::F_XOR: begin
        o_res = i_src1 ^ i_src2;
      end
      exu_pkg::F_SRL: begin
        if (i_alt) begin
          o_res = $unsigned($signed(i_src1) >>> shamt);
        end else begin
          o_res = i_src1 >> shamt;
        end
      end
      exu_pkg::F_OR: begin
        o_res = i_src1 | i_src2;
      end
      exu_pkg::F_AND: begin
        o_res = i_src1 & i_src2;
      end
      default: begin
        o_res = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/exu_branch.sv ====
`default_nettype none

module exu_branch (
  input  wire [2:0]               i_func,
  input  wire                     i_eq,
  input  wire                     i_lt,
  input  wire                     i_ltu,
  input  wire [exu_pkg::XLEN-1:0] i_pc,
  input  wire [exu_pkg::XLEN-1:0] i_imm,
  output logic                    o_taken,
  output logic [exu_pkg::XLEN-1:0] o_pc_next,
  output logic [exu_pkg::XLEN-1:0] o_pc_seq
);

  logic [exu_pkg::XLEN-1:0] pc_tgt;

  always_comb begin
    case (i_func)
      exu_pkg::B_EQ:  o_taken = i_eq;
      exu_pkg::B_NE:  o_taken = !i_eq;
      exu_pkg::B_LT:  o_taken = i_lt;
      exu_pkg::B_GE:  o_taken = !i_lt;
      exu_pkg::B_LTU: o_taken = i_ltu;
      exu_pkg::B_GEU: o_taken = !i_ltu;
      default:        o_taken = 1'b0;
    endcase
  end

  // fall-through pc, also the next pc of every non-branch
  assign o_pc_seq = i_pc + {{(exu_pkg::XLEN - 3){1'b0}}, 3'd4};
  assign pc_tgt = i_pc + i_imm;
  assign o_pc_next = o_taken ? pc_tgt : o_pc_seq;

endmodule

`default_nettype wire

// ==== logic/exu_pkg.sv ====
`default_nettype none

package exu_pkg;

  localparam int XLEN = 32;
  localparam int SHAMT_W = $clog2(XLEN);

  // instruction class
  localparam logic [1:0] OP_ALU = 2'd0;
  localparam logic [1:0] OP_BRANCH = 2'd1;
  localparam logic [1:0] OP_LOAD = 2'd2;
  localparam logic [1:0] OP_STORE = 2'd3;

  // alu funct3, alt bit turns add into sub and srl into sra
  localparam logic [2:0] F_ADD = 3'b000;
  localparam logic [2:0] F_SLL = 3'b001;
  localparam logic [2:0] F_SLT = 3'b010;
  localparam logic [2:0] F_SLTU = 3'b011;
  localparam logic [2:0] F_XOR = 3'b100;
  localparam logic [2:0] F_SRL = 3'b101;
  localparam logic [2:0] F_OR = 3'b110;
  localparam logic [2:0] F_AND = 3'b111;

  // branch funct3
  localparam logic [2:0] B_EQ = 3'b000;
  localparam logic [2:0] B_NE = 3'b001;
  localparam logic [2:0] B_LT = 3'b100;
  localparam logic [2:0] B_GE = 3'b101;
  localparam logic [2:0] B_LTU = 3'b110;
  localparam logic [2:0] B_GEU = 3'b111;

  // load/store width
  localparam logic [2:0] W_BYTE = 3'b000;
  localparam logic [2:0] W_HALF = 3'b001;
  localparam logic [2:0] W_WORD = 3'b010;
  localparam logic [2:0] W_BYTEU = 3'b100;
  localparam logic [2:0] W_HALFU = 3'b101;

  // cycles to wait for R or B
  localparam int LSU_TIMEOUT = 16;
  localparam int LSU_TIMER_W = $clog2(LSU_TIMEOUT + 1);

  localparam logic [1:0] RESP_OKAY = 2'b00;

  // lsu sequencer states
  localparam int ST_W = 3;
  localparam logic [ST_W-1:0] ST_IDLE = 3'd0;
  localparam logic [ST_W-1:0] ST_RADDR = 3'd1;
  localparam logic [ST_W-1:0] ST_RWAIT = 3'd2;
  localparam logic [ST_W-1:0] ST_WADDR = 3'd3;
  localparam logic [ST_W-1:0] ST_WWAIT = 3'd4;
  localparam logic [ST_W-1:0] ST_DONE = 3'd5;

endpackage

`default_nettype wire

// ==== logic/exu_top.sv ====
`default_nettype none

module exu_top (
  input  wire                        clock,
  input  wire                        i_rst_n,
  input  wire                        i_pre_valid,
  input  wire [1:0]                  i_op_class,
  input  wire [2:0]                  i_func,
  input  wire                        i_alt,
  input  wire [exu_pkg::XLEN-1:0]    i_src1,
  input  wire [exu_pkg::XLEN-1:0]    i_src2,
  input  wire [exu_pkg::XLEN-1:0]    i_imm,
  input  wire [exu_pkg::XLEN-1:0]    i_pc,
  input  wire                        i_post_ready,
  output logic                       o_pre_ready,
  output logic                       o_post_valid,
  output logic [exu_pkg::XLEN-1:0]   o_res,
  output logic [exu_pkg::XLEN-1:0]   o_pc_next,
  output logic                       o_brch_taken,
  output logic                       o_fault,
  output logic [exu_pkg::XLEN-1:0]   o_axi_araddr,
  output logic                       o_axi_arvalid,
  input  wire                        i_axi_arready,
  input  wire [exu_pkg::XLEN-1:0]    i_axi_rdata,
  input  wire [1:0]                  i_axi_rresp,
  input  wire                        i_axi_rvalid,
  output logic                       o_axi_rready,
  output logic [exu_pkg::XLEN-1:0]   o_axi_awaddr,
  output logic                       o_axi_awvalid,
  input  wire                        i_axi_awready,
  output logic [exu_pkg::XLEN-1:0]   o_axi_wdata,
  output logic [exu_pkg::XLEN/8-1:0] o_axi_wstrb,
  output logic                       o_axi_wvalid,
  input  wire                        i_axi_wready,
  input  wire [1:0]                  i_axi_bresp,
  input  wire                        i_axi_bvalid,
  output logic                       o_axi_bready
);

  logic [exu_pkg::XLEN-1:0] alu_res;
  logic [exu_pkg::XLEN-1:0] pc_next;
  logic [exu_pkg::XLEN-1:0] pc_seq;
  logic eq;
  logic lt;
  logic ltu;
  logic taken;
  logic capture;
  logic result_load;
  logic load_capture;
  logic brch;
  logic timer_run;
  logic timeout;

  exu_alu u_alu (
    .i_func (i_func),
    .i_alt  (i_alt),
    .i_src1 (i_src1),
    .i_src2 (i_src2),
    .o_res  (alu_res),
    .o_eq   (eq),
    .o_lt   (lt),
    .o_ltu  (ltu)
  );

  exu_branch u_branch (
    .i_func    (i_func),
    .i_eq      (eq),
    .i_lt      (lt),
    .i_ltu     (ltu),
    .i_pc      (i_pc),
    .i_imm     (i_imm),
    .o_taken   (taken),
    .o_pc_next (pc_next),
    .o_pc_seq  (pc_seq)
  );

  lsu_ctrl_fsm u_fsm (
    .clock          (clock),
    .i_rst_n        (i_rst_n),
    .i_pre_valid    (i_pre_valid),
    .i_op_class     (i_op_class),
    .i_post_ready   (i_post_ready),
    .i_timeout      (timeout),
    .i_axi_arready  (i_axi_arready),
    .i_axi_rvalid   (i_axi_rvalid),
    .i_axi_rresp    (i_axi_rresp),
    .i_axi_awready  (i_axi_awready),
    .i_axi_wready   (i_axi_wready),
    .i_axi_bvalid   (i_axi_bvalid),
    .i_axi_bresp    (i_axi_bresp),
    .o_pre_ready    (o_pre_ready),
    .o_post_valid   (o_post_valid),
    .o_capture      (capture),
    .o_result_load  (result_load),
    .o_load_capture (load_capture),
    .o_fault        (o_fault),
    .o_brch         (brch),
    .o_timer_run    (timer_run),
    .o_axi_arvalid  (o_axi_arvalid),
    .o_axi_rready   (o_axi_rready),
    .o_axi_awvalid  (o_axi_awvalid),
    .o_axi_wvalid   (o_axi_wvalid),
    .o_axi_bready   (o_axi_bready)
  );

  lsu_wait_timer u_timer (
    .clock     (clock),
    .i_rst_n   (i_rst_n),
    .i_run     (timer_run),
    .o_timeout (timeout)
  );

  lsu_data_path u_data (
    .clock          (clock),
    .i_rst_n        (i_rst_n),
    .i_capture      (capture),
    .i_result_load  (result_load),
    .i_load_capture (load_capture),
    .i_fault        (o_fault),
    .i_brch         (brch),
    .i_func         (i_func),
    .i_src1         (i_src1),
    .i_src2         (i_src2),
    .i_imm          (i_imm),
    .i_alu_res      (alu_res),
    .i_taken        (taken),
    .i_pc_next      (pc_next),
    .i_pc_seq       (pc_seq),
    .i_axi_rdata    (i_axi_rdata),
    .o_res          (o_res),
    .o_pc_next      (o_pc_next),
    .o_taken        (o_brch_taken),
    .o_axi_araddr   (o_axi_araddr),
    .o_axi_awaddr   (o_axi_awaddr),
    .o_axi_wdata    (o_axi_wdata),
    .o_axi_wstrb    (o_axi_wstrb)
  );

endmodule

`default_nettype wire

// ==== logic/lsu_ctrl_fsm.sv ====
`default_nettype none

module lsu_ctrl_fsm (
  input  wire       clock,
  input  wire       i_rst_n,
  input  wire       i_pre_valid,
  input  wire [1:0] i_op_class,
  input  wire       i_post_ready,
  input  wire       i_timeout,
  input  wire       i_axi_arready,
  input  wire       i_axi_rvalid,
  input  wire [1:0] i_axi_rresp,
  input  wire       i_axi_awready,
  input  wire       i_axi_wready,
  input  wire       i_axi_bvalid,
  input  wire [1:0] i_axi_bresp,
  output logic      o_pre_ready,
  output logic      o_post_valid,
  output logic      o_capture,
  output logic      o_result_load,
  output logic      o_load_capture,
  output logic      o_fault,
  output logic      o_brch,
  output logic      o_timer_run,
  output logic      o_axi_arvalid,
  output logic      o_axi_rready,
  output logic      o_axi_awvalid,
  output logic      o_axi_wvalid,
  output logic      o_axi_bready
);

  logic [exu_pkg::ST_W-1:0] state;
  logic [exu_pkg::ST_W-1:0] state_nxt;
  logic [1:0] op_q;
  logic aw_done;
  logic w_done;
  logic accept;
  logic aw_fire;
  logic w_fire;

  assign o_pre_ready = (state == exu_pkg::ST_IDLE);
  assign accept = i_pre_valid && o_pre_ready;
  assign o_capture = accept;
  assign o_result_load = accept &&
                         (i_op_class == exu_pkg::OP_ALU || i_op_class == exu_pkg::OP_BRANCH);
  assign o_post_valid = (state == exu_pkg::ST_DONE);
  assign o_brch = (op_q == exu_pkg::OP_BRANCH);

  assign o_axi_arvalid = (state == exu_pkg::ST_RADDR);
  assign o_axi_rready = (state == exu_pkg::ST_RWAIT);
  assign o_axi_awvalid = (state == exu_pkg::ST_WADDR) && !aw_done;
  assign o_axi_wvalid = (state == exu_pkg::ST_WADDR) && !w_done;
  assign o_axi_bready = (state == exu_pkg::ST_WWAIT);
  assign aw_fire = o_axi_awvalid && i_axi_awready;
  assign w_fire = o_axi_wvalid && i_axi_wready;

  // timer only runs while a response is owed
  assign o_timer_run = o_axi_rready || o_axi_bready;
  assign o_load_capture = o_axi_rready && i_axi_rvalid;

  always_comb begin
    state_nxt = state;
    case (state)
      exu_pkg::ST_IDLE: begin
        if (accept) begin
          case (i_op_class)
            exu_pkg::OP_LOAD:  state_nxt = exu_pkg::ST_RADDR;
            exu_pkg::OP_STORE: state_nxt = exu_pkg::ST_WADDR;
            default:           state_nxt = exu_pkg::ST_DONE;
          endcase
        end
      end
      exu_pkg::ST_RADDR: begin
        if (i_axi_arready) begin
          state_nxt = exu_pkg::ST_RWAIT;
        end
      end
      exu_pkg::ST_RWAIT: begin
        if (i_axi_rvalid || i_timeout) begin
          state_nxt = exu_pkg::ST_DONE;
        end
      end
      exu_pkg::ST_WADDR: begin
        // aw and w may finish in either order
        if ((aw_done || aw_fire) && (w_done || w_fire)) begin
          state_nxt = exu_pkg::ST_WWAIT;
        end
      end
      exu_pkg::ST_WWAIT: begin
        if (i_axi_bvalid || i_timeout) begin
          state_nxt = exu_pkg::ST_DONE;
        end
      end
      exu_pkg::ST_DONE: begin
        if (i_post_ready) begin
          state_nxt = exu_pkg::ST_IDLE;
        end
      end
      default: begin
        state_nxt = exu_pkg::ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clock or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state <= exu_pkg::ST_IDLE;
      op_q <= exu_pkg::OP_ALU;
      aw_done <= 1'b0;
      w_done <= 1'b0;
      o_fault <= 1'b0;
    end else begin
      state <= state_nxt;
      if (accept) begin
        op_q <= i_op_class;
      end
      if (state == exu_pkg::ST_WADDR) begin
        aw_done <= aw_done || aw_fire;
        w_done <= w_done || w_fire;
      end else begin
        aw_done <= 1'b0;
        w_done <= 1'b0;
      end
      // a response wins over a timeout in the same cycle
      if (o_axi_rready && i_axi_rvalid) begin
        o_fault <= (i_axi_rresp != exu_pkg::RESP_OKAY);
      end else if (o_axi_bready && i_axi_bvalid) begin
        o_fault <= (i_axi_bresp != exu_pkg::RESP_OKAY);
      end else if (o_timer_run && i_timeout) begin
        o_fault <= 1'b1;
      end else if (o_post_valid && i_post_ready) begin
        o_fault <= 1'b0;
      end
    end
  end

  assert property (@(posedge clock) disable iff (!i_rst_n)
    o_axi_arvalid && !i_axi_arready |=> o_axi_arvalid);

  // result and bus request never overlap, and no request is pending just before it
  assert property (@(posedge clock) disable iff (!i_rst_n)
    o_post_valid |-> !(o_axi_arvalid || o_axi_awvalid || o_axi_wvalid) &&
                     !$past(o_axi_arvalid || o_axi_awvalid || o_axi_wvalid));

endmodule

`default_nettype wire

// ==== logic/lsu_data_path.sv ====
`default_nettype none

module lsu_data_path (
  input  wire                       clock,
  input  wire                       i_rst_n,
  input  wire                       i_capture,
  input  wire                       i_result_load,
  input  wire                       i_load_capture,
  input  wire                       i_fault,
  input  wire                       i_brch,
  input  wire [2:0]                 i_func,
  input  wire [exu_pkg::XLEN-1:0]   i_src1,
  input  wire [exu_pkg::XLEN-1:0]   i_src2,
  input  wire [exu_pkg::XLEN-1:0]   i_imm,
  input  wire [exu_pkg::XLEN-1:0]   i_alu_res,
  input  wire                       i_taken,
  input  wire [exu_pkg::XLEN-1:0]   i_pc_next,
  input  wire [exu_pkg::XLEN-1:0]   i_pc_seq,
  input  wire [exu_pkg::XLEN-1:0]   i_axi_rdata,
  output logic [exu_pkg::XLEN-1:0]  o_res,
  output logic [exu_pkg::XLEN-1:0]  o_pc_next,
  output logic                      o_taken,
  output logic [exu_pkg::XLEN-1:0]  o_axi_araddr,
  output logic [exu_pkg::XLEN-1:0]  o_axi_awaddr,
  output logic [exu_pkg::XLEN-1:0]  o_axi_wdata,
  output logic [exu_pkg::XLEN/8-1:0] o_axi_wstrb
);

  logic [exu_pkg::XLEN-1:0] addr;
  logic [exu_pkg::XLEN-1:0] addr_q;
  logic [exu_pkg::XLEN-1:0] res_q;
  logic [exu_pkg::XLEN-1:0] pc_next_q;
  logic [exu_pkg::XLEN-1:0] pc_seq_q;
  logic [exu_pkg::XLEN-1:0] rshift;
  logic [exu_pkg::XLEN-1:0] load_val;
  logic [exu_pkg::XLEN/8-1:0] strb_nxt;
  logic [2:0] width_q;
  logic taken_q;

  assign addr = i_src1 + i_imm;

  // byte lanes for the store
  always_comb begin
    case (i_func)
      exu_pkg::W_BYTE, exu_pkg::W_BYTEU: strb_nxt = 4'b0001 << addr[1:0];
      exu_pkg::W_HALF, exu_pkg::W_HALFU: strb_nxt = 4'b0011 << addr[1:0];
      exu_pkg::W_WORD:                   strb_nxt = 4'b1111;
      default:                           strb_nxt = 4'b0000;
    endcase
  end

  // pull the addressed lane down to bit 0, then extend
  assign rshift = i_axi_rdata >> {addr_q[1:0], 3'b000};

  always_comb begin
    case (width_q)
      exu_pkg::W_BYTE:  load_val = {{(exu_pkg::XLEN - 8){rshift[7]}}, rshift[7:0]};
      exu_pkg::W_BYTEU: load_val = {{(exu_pkg::XLEN - 8){1'b0}}, rshift[7:0]};
      exu_pkg::W_HALF:  load_val = {{(exu_pkg::XLEN - 16){rshift[15]}}, rshift[15:0]};
      exu_pkg::W_HALFU: load_val = {{(exu_pkg::XLEN - 16){1'b0}}, rshift[15:0]};
      default:          load_val = rshift;
    endcase
  end

  always_ff @(posedge clock) begin
    if (i_capture) begin
      addr_q <= addr;
      width_q <= i_func;
      o_axi_wdata <= i_src2 << {addr[1:0], 3'b000};
      pc_next_q <= i_pc_next;
      pc_seq_q <= i_pc_seq;
      res_q <= '0;
    end
    if (i_result_load) begin
      res_q <= i_alu_res;
    end else if (i_load_capture) begin
      res_q <= load_val;
    end
  end

  always_ff @(posedge clock or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_axi_wstrb <= '0;
      taken_q <= 1'b0;
    end else if (i_capture) begin
      o_axi_wstrb <= strb_nxt;
      taken_q <= i_taken;
    end
  end

  assign o_axi_araddr = addr_q;
  assign o_axi_awaddr = addr_q;

  // branches report the taken bit, faulted accesses report zero
  assign o_res = i_fault ? '0 :
                 i_brch ? {{(exu_pkg::XLEN - 1){1'b0}}, taken_q} : res_q;
  assign o_taken = i_brch && taken_q;
  assign o_pc_next = o_taken ? pc_next_q : pc_seq_q;

endmodule

`default_nettype wire

// ==== logic/lsu_wait_timer.sv ====
`default_nettype none

module lsu_wait_timer (
  input  wire  clock,
  input  wire  i_rst_n,
  input  wire  i_run,
  output logic o_timeout
);

  logic [exu_pkg::LSU_TIMER_W-1:0] count;

  // saturates so the timeout fires once per wait
  always_ff @(posedge clock or negedge i_rst_n) begin
    if (!i_rst_n) begin
      count <= '0;
    end else if (!i_run) begin
      count <= '0;
    end else if (count != exu_pkg::LSU_TIMEOUT[exu_pkg::LSU_TIMER_W-1:0]) begin
      count <= count + 1'b1;
    end
  end

  assign o_timeout = i_run &&
                     (count == exu_pkg::LSU_TIMEOUT[exu_pkg::LSU_TIMER_W-1:0] - 1'b1);

  // run held for the whole wait before a timeout
  assert property (@(posedge clock) disable iff (!i_rst_n)
    o_timeout |-> i_run && $past(i_run, exu_pkg::LSU_TIMEOUT - 1));

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module exu_tb -f all.f -o exu_sim \
  && ./obj_dir/exu_sim \
  || { echo "exu simulation failed"; exit 1; }

// ==== verification/axi_mem_model.sv ====
`default_nettype none

module axi_mem_model (
  input  wire                        clock,
  input  wire [exu_pkg::XLEN-1:0]    i_araddr,
  input  wire                        i_arvalid,
  output logic                       o_arready,
  output logic [exu_pkg::XLEN-1:0]   o_rdata,
  output logic [1:0]                 o_rresp,
  output logic                       o_rvalid,
  input  wire                        i_rready,
  input  wire [exu_pkg::XLEN-1:0]    i_awaddr,
  input  wire                        i_awvalid,
  output logic                       o_awready,
  input  wire [exu_pkg::XLEN-1:0]    i_wdata,
  input  wire [exu_pkg::XLEN/8-1:0]  i_wstrb,
  input  wire                        i_wvalid,
  output logic                       o_wready,
  output logic [1:0]                 o_bresp,
  output logic                       o_bvalid,
  input  wire                        i_bready
);

  // 1 KiB, word indexed
  logic [exu_pkg::XLEN-1:0] mem [0:255];

  initial begin : clear_mem
    for (int k = 0; k < 256; k++) begin
      mem[k] = '0;
    end
  end

  initial begin : read_side
    logic [exu_pkg::XLEN-1:0] addr;
    int wait_cyc;
    o_arready = 1'b0;
    o_rvalid = 1'b0;
    o_rdata = '0;
    o_rresp = exu_pkg::RESP_OKAY;
    forever begin
      @(posedge clock);
      #1;
      if (i_arvalid) begin
        wait_cyc = $urandom_range(3, 0);
        repeat (wait_cyc) begin
          @(posedge clock);
          #1;
        end
        o_arready = 1'b1;
        addr = i_araddr;
        @(posedge clock);
        #1;
        o_arready = 1'b0;
        // bit 31 region never answers
        if (!addr[31]) begin
          wait_cyc = $urandom_range(3, 0);
          repeat (wait_cyc) begin
            @(posedge clock);
            #1;
          end
          o_rvalid = 1'b1;
          // slverr for the bit 30 region, with junk data on the beat
          o_rresp = addr[30] ? 2'b10 : exu_pkg::RESP_OKAY;
          o_rdata = addr[30] ? ~addr : mem[addr[9:2]];
          while (!i_rready) begin
            @(posedge clock);
            #1;
          end
          @(posedge clock);
          #1;
          o_rvalid = 1'b0;
        end
      end
    end
  end

  initial begin : write_side
    logic [exu_pkg::XLEN-1:0] addr;
    logic [exu_pkg::XLEN-1:0] data;
    logic [exu_pkg::XLEN/8-1:0] strb;
    logic aw_ok;
    logic w_ok;
    int aw_wait;
    int w_wait;
    int cyc;
    int wait_cyc;
    o_awready = 1'b0;
    o_wready = 1'b0;
    o_bvalid = 1'b0;
    o_bresp = exu_pkg::RESP_OKAY;
    addr = '0;
    data = '0;
    strb = '0;
    forever begin
      @(posedge clock);
      #1;
      if (i_awvalid && i_wvalid) begin
        aw_wait = $urandom_range(3, 0);
        w_wait = $urandom_range(3, 0);
        aw_ok = 1'b0;
        w_ok = 1'b0;
        cyc = 0;
        // aw and w accepted independently
        while (!(aw_ok && w_ok)) begin
          o_awready = !aw_ok && (cyc >= aw_wait);
          o_wready = !w_ok && (cyc >= w_wait);
          if (o_awready) begin
            addr = i_awaddr;
          end
          if (o_wready) begin
            data = i_wdata;
            strb = i_wstrb;
          end
          @(posedge clock);
          #1;
          aw_ok = aw_ok || o_awready;
          w_ok = w_ok || o_wready;
          cyc++;
        end
        o_awready = 1'b0;
        o_wready = 1'b0;
        if (!addr[31] && !addr[30]) begin
          for (int b = 0; b < exu_pkg::XLEN / 8; b++) begin
            if (strb[b]) begin
              mem[addr[9:2]][8*b +: 8] = data[8*b +: 8];
            end
          end
        end
        if (!addr[31]) begin
          wait_cyc = $urandom_range(3, 0);
          repeat (wait_cyc) begin
            @(posedge clock);
            #1;
          end
          o_bvalid = 1'b1;
          o_bresp = addr[30] ? 2'b10 : exu_pkg::RESP_OKAY;
          while (!i_bready) begin
            @(posedge clock);
            #1;
          end
          @(posedge clock);
          #1;
          o_bvalid = 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== verification/exu_golden.txt ====
# name class func alt src1 src2 imm pc | expected: res pc_next taken fault
# all fields hex; class 0 alu, 1 branch, 2 load, 3 store
add 0 0 0 00000005 00000007 00000000 00000100 0000000c 00000104 0 0
sub 0 0 1 00000005 00000007 00000000 00000104 fffffffe 00000108 0 0
sll 0 1 0 80000001 00000024 00000000 00000108 00000010 0000010c 0 0
slt 0 2 0 ffffffff 00000001 00000000 0000010c 00000001 00000110 0 0
sltu 0 3 0 ffffffff 00000001 00000000 00000110 00000000 00000114 0 0
xor 0 4 0 ff00ff00 0f0f0f0f 00000000 00000114 f00ff00f 00000118 0 0
srl 0 5 0 80000000 00000004 00000000 00000118 08000000 0000011c 0 0
sra 0 5 1 80000000 00000004 00000000 0000011c f8000000 00000120 0 0
or 0 6 0 12340000 00005678 00000000 00000120 12345678 00000124 0 0
and 0 7 0 f0f0f0f0 ff00ff00 00000000 00000124 f000f000 00000128 0 0
beq 1 0 0 00000010 00000010 00000040 00000200 00000001 00000240 1 0
bne 1 1 0 00000010 00000010 00000040 00000204 00000000 00000208 0 0
blt 1 4 0 fffffff0 00000004 fffffff8 00000208 00000001 00000200 1 0
bge 1 5 0 fffffff0 00000004 fffffff8 0000020c 00000000 00000210 0 0
bltu 1 6 0 fffffff0 00000004 fffffff8 00000210 00000000 00000214 0 0
bgeu 1 7 0 fffffff0 00000004 00000100 00000214 00000001 00000314 1 0
sw 3 2 0 00000100 11223344 00000000 00000300 00000000 00000304 0 0
sb 3 0 0 00000100 000000a5 00000001 00000304 00000000 00000308 0 0
sh 3 1 0 00000100 0000f00d 00000002 00000308 00000000 0000030c 0 0
lw 2 2 0 00000100 00000000 00000000 0000030c f00da544 00000310 0 0
lb 2 0 0 00000100 00000000 00000001 00000310 ffffffa5 00000314 0 0
lbu 2 4 0 00000100 00000000 00000001 00000314 000000a5 00000318 0 0
lh 2 1 0 00000100 00000000 00000002 00000318 fffff00d 0000031c 0 0
lhu 2 5 0 00000100 00000000 00000002 0000031c 0000f00d 00000320 0 0
lb_low 2 0 0 00000100 00000000 00000000 00000320 00000044 00000324 0 0
lw_slverr 2 2 0 40000000 00000000 00000000 00000400 00000000 00000404 0 1
sw_slverr 3 2 0 40000010 deadbeef 00000000 00000404 00000000 00000408 0 1
lw_noresp 2 2 0 80000000 00000000 00000000 00000408 00000000 0000040c 0 1
sw_noresp 3 2 0 80000004 cafef00d 00000000 0000040c 00000000 00000410 0 1
add_after 0 0 0 00000001 00000002 00000000 00000410 00000003 00000414 0 0
lw_after 2 2 0 00000100 00000000 00000000 00000414 f00da544 00000418 0 0

// ==== verification/exu_tb.sv ====
`default_nettype none

module exu_tb;

  localparam int MAX_TESTS = 64;

  logic clock;
  logic rst_n;
  logic pre_valid;
  logic [1:0] op_class;
  logic [2:0] func;
  logic alt;
  logic [exu_pkg::XLEN-1:0] src1;
  logic [exu_pkg::XLEN-1:0] src2;
  logic [exu_pkg::XLEN-1:0] imm;
  logic [exu_pkg::XLEN-1:0] pc;
  logic post_ready;
  logic pre_ready;
  logic post_valid;
  logic [exu_pkg::XLEN-1:0] res;
  logic [exu_pkg::XLEN-1:0] pc_next;
  logic brch_taken;
  logic fault;
  logic [exu_pkg::XLEN-1:0] araddr;
  logic arvalid;
  logic arready;
  logic [exu_pkg::XLEN-1:0] rdata;
  logic [1:0] rresp;
  logic rvalid;
  logic rready;
  logic [exu_pkg::XLEN-1:0] awaddr;
  logic awvalid;
  logic awready;
  logic [exu_pkg::XLEN-1:0] wdata;
  logic [exu_pkg::XLEN/8-1:0] wstrb;
  logic wvalid;
  logic wready;
  logic [1:0] bresp;
  logic bvalid;
  logic bready;

  // one entry per golden line
  string t_name [MAX_TESTS];
  logic [1:0] t_class [MAX_TESTS];
  logic [2:0] t_func [MAX_TESTS];
  logic t_alt [MAX_TESTS];
  logic [exu_pkg::XLEN-1:0] t_src1 [MAX_TESTS];
  logic [exu_pkg::XLEN-1:0] t_src2 [MAX_TESTS];
  logic [exu_pkg::XLEN-1:0] t_imm [MAX_TESTS];
  logic [exu_pkg::XLEN-1:0] t_pc [MAX_TESTS];
  logic [exu_pkg::XLEN-1:0] t_res [MAX_TESTS];
  logic [exu_pkg::XLEN-1:0] t_pc_next [MAX_TESTS];
  logic t_taken [MAX_TESTS];
  logic t_fault [MAX_TESTS];
  int n_tests;
  logic golden_read;

  exu_top DUT (
    .clock (clock), .i_rst_n (rst_n),
    .i_pre_valid (pre_valid), .i_op_class (op_class), .i_func (func), .i_alt (alt),
    .i_src1 (src1), .i_src2 (src2), .i_imm (imm), .i_pc (pc),
    .i_post_ready (post_ready), .o_pre_ready (pre_ready), .o_post_valid (post_valid),
    .o_res (res), .o_pc_next (pc_next), .o_brch_taken (brch_taken), .o_fault (fault),
    .o_axi_araddr (araddr), .o_axi_arvalid (arvalid), .i_axi_arready (arready),
    .i_axi_rdata (rdata), .i_axi_rresp (rresp), .i_axi_rvalid (rvalid),
    .o_axi_rready (rready), .o_axi_awaddr (awaddr), .o_axi_awvalid (awvalid),
    .i_axi_awready (awready), .o_axi_wdata (wdata), .o_axi_wstrb (wstrb),
    .o_axi_wvalid (wvalid), .i_axi_wready (wready), .i_axi_bresp (bresp),
    .i_axi_bvalid (bvalid), .o_axi_bready (bready)
  );

  axi_mem_model u_mem (
    .clock (clock),
    .i_araddr (araddr), .i_arvalid (arvalid), .o_arready (arready),
    .o_rdata (rdata), .o_rresp (rresp), .o_rvalid (rvalid), .i_rready (rready),
    .i_awaddr (awaddr), .i_awvalid (awvalid), .o_awready (awready),
    .i_wdata (wdata), .i_wstrb (wstrb), .i_wvalid (wvalid), .o_wready (wready),
    .o_bresp (bresp), .o_bvalid (bvalid), .i_bready (bready)
  );

  initial begin : clock_gen
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  task automatic check_word(input string name, input string what,
                            input logic [exu_pkg::XLEN-1:0] exp,
                            input logic [exu_pkg::XLEN-1:0] act);
    if (act !== exp) begin
      $display("Error: %s %s expected %h actual %h", name, what, exp, act);
      $display("** FAIL **");
      $fatal(1);
    end
  endtask

  task automatic check_pc(input string name, input string what,
                          input logic [exu_pkg::XLEN-1:0] exp,
                          input logic [exu_pkg::XLEN-1:0] act);
    if (act !== exp) begin
      $display("Error: %s %s expected %h actual %h", name, what, exp, act);
      $display("** FAIL **");
      $fatal(1);
    end
  endtask

  task automatic check_flag(input string name, input string what,
                            input logic exp, input logic act);
    if (act !== exp) begin
      $display("Error: %s %s expected %b actual %b", name, what, exp, act);
      $display("** FAIL **");
      $fatal(1);
    end
  endtask

  task automatic load_golden();
    int fd;
    int n_fields;
    string line;
    fd = $fopen("verification/exu_golden.txt", "r");
    if (fd == 0) begin
      $display("Cannot open verification/exu_golden.txt");
      $display("** FAIL **");
      $fatal(1);
    end
    n_tests = 0;
    while (!$feof(fd) && n_tests < MAX_TESTS) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 1 && line.substr(0, 0) != "#") begin
        n_fields = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h",
                           t_name[n_tests], t_class[n_tests], t_func[n_tests],
                           t_alt[n_tests], t_src1[n_tests], t_src2[n_tests],
                           t_imm[n_tests], t_pc[n_tests], t_res[n_tests],
                           t_pc_next[n_tests], t_taken[n_tests], t_fault[n_tests]);
        if (n_fields != 12) begin
          $display("Malformed golden line: %s", line);
          $display("** FAIL **");
          $fatal(1);
        end
        n_tests++;
      end
    end
    $fclose(fd);
  endtask

  task automatic check_result(input int i);
    check_word(t_name[i], "res", t_res[i], res);
    check_pc(t_name[i], "pc_next", t_pc_next[i], pc_next);
    check_flag(t_name[i], "taken", t_taken[i], brch_taken);
    check_flag(t_name[i], "fault", t_fault[i], fault);
  endtask

  // called 1 unit after a rising edge, with the stage idle
  task automatic run_test(input int i);
    int stall;
    op_class = t_class[i];
    func = t_func[i];
    alt = t_alt[i];
    src1 = t_src1[i];
    src2 = t_src2[i];
    imm = t_imm[i];
    pc = t_pc[i];
    pre_valid = 1'b1;
    while (!pre_ready) begin
      @(posedge clock);
      #1;
    end
    @(posedge clock);
    #1;
    pre_valid = 1'b0;
    if (t_class[i] == exu_pkg::OP_ALU || t_class[i] == exu_pkg::OP_BRANCH) begin
      check_flag(t_name[i], "post_valid one cycle after accept", 1'b1, post_valid);
    end
    while (!post_valid) begin
      @(posedge clock);
      #1;
    end
    check_result(i);
    stall = $urandom_range(2, 0);
    repeat (stall) begin
      @(posedge clock);
      #1;
      check_flag(t_name[i], "post_valid held under stall", 1'b1, post_valid);
      check_flag(t_name[i], "pre_ready under stall", 1'b0, pre_ready);
      check_result(i);
    end
    post_ready = 1'b1;
    @(posedge clock);
    #1;
    post_ready = 1'b0;
    check_flag(t_name[i], "post_valid after handshake", 1'b0, post_valid);
  endtask

  initial begin : watchdog
    int limit;
    wait (golden_read);
    limit = n_tests * (exu_pkg::LSU_TIMEOUT + 20) + 10;
    repeat (limit) @(posedge clock);
    $display("Watchdog expired after %0d cycles, the DUT stopped responding", limit);
    $display("** FAIL **");
    $fatal(1);
  end

  initial begin : main
    rst_n = 1'b0;
    pre_valid = 1'b0;
    op_class = exu_pkg::OP_ALU;
    func = '0;
    alt = 1'b0;
    src1 = '0;
    src2 = '0;
    imm = '0;
    pc = '0;
    post_ready = 1'b0;
    golden_read = 1'b0;
    void'($urandom(10826));
    load_golden();
    golden_read = 1'b1;
    repeat (2) @(posedge clock);
    #1;
    rst_n = 1'b1;
    check_flag("reset", "post_valid", 1'b0, post_valid);
    check_flag("reset", "arvalid", 1'b0, arvalid);
    check_flag("reset", "awvalid", 1'b0, awvalid);
    check_flag("reset", "wvalid", 1'b0, wvalid);
    check_flag("reset", "rready", 1'b0, rready);
    check_flag("reset", "bready", 1'b0, bready);
    check_flag("reset", "pre_ready", 1'b1, pre_ready);
    for (int i = 0; i < n_tests; i++) begin
      run_test(i);
    end
    if (n_tests == 0) begin
      $display("No tests found in the golden file");
      $display("** FAIL **");
      $fatal(1);
    end else begin
      $display("** PASS **");
      $finish;
    end
  end

endmodule

`default_nettype wire
